//--- list.f
rtl/mem_msg_pkg.sv
rtl/host_map_pkg.sv
rtl/burst_to_lite.sv
rtl/lite_to_burst.sv
rtl/host_regs.sv
rtl/host_bridge_top.sv
verification/host_bridge_checker.sv
verification/host_bridge_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= host_bridge_tb
BUILD_DIR ?= build
SEED      ?= 97460
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' list.f)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): list.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f list.f --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	@./$(BIN) +verilator+seed+$(SEED) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/host_bridge_tb.sv
// Host bridge testbench
`timescale 1ns/1ps
`default_nettype none

module host_bridge_tb;

  import mem_msg_pkg::*;
  import host_map_pkg::*;

  localparam int beat_width_lp   = 32;
  localparam int num_core_lp     = 4;
  localparam int num_trace_lp    = 4;
  localparam int num_unmapped_lp = 4;
  localparam int num_random_lp   = 200;
  localparam int num_req_lp      = 2 * num_trace_lp + 4 * num_core_lp + 1
                                   + 2 * num_unmapped_lp + 8 + num_random_lp;
  localparam int timeout_cycles_lp = num_req_lp * 64 + 1000;

  localparam logic [3:0] t_trace_lp    = 4'd1;
  localparam logic [3:0] t_finish_lp   = 4'd2;
  localparam logic [3:0] t_unmapped_lp = 4'd3;
  localparam logic [3:0] t_sizes_lp    = 4'd4;
  localparam logic [3:0] t_random_lp   = 4'd5;

  typedef struct packed {
    logic [num_core_lp-1:0] finish;
    trace_en_s              trace;
  } regs_model_s;

  logic                     clk;
  logic                     rst_n;
  mem_header_s              fwd_header;
  logic                     fwd_header_v;
  logic                     fwd_has_data;
  logic                     fwd_header_ready_and;
  logic [beat_width_lp-1:0] fwd_data;
  logic                     fwd_data_v;
  logic                     fwd_last;
  logic                     fwd_data_ready_and;
  mem_header_s              rev_header;
  logic                     rev_header_v;
  logic                     rev_has_data;
  logic                     rev_header_ready_and;
  logic [beat_width_lp-1:0] rev_data;
  logic                     rev_data_v;
  logic                     rev_last;
  logic                     rev_data_ready_and;
  logic [num_core_lp-1:0]   finish;
  trace_en_s                trace_en;

  logic                     exp_push;
  logic [3:0]               exp_test;
  mem_header_s              exp_header;
  logic [63:0]              exp_data;
  logic [3:0]               exp_beats;
  logic [num_core_lp-1:0]   exp_finish;
  trace_en_s                exp_trace;
  int                       error_count;
  int                       resp_count;

  regs_model_s              model;
  int                       sent;
  int                       k;
  logic [19:0]              addr;
  mem_op_e                  op;
  mem_size_e                size;

  host_bridge_top #(
    .beat_width_p(beat_width_lp),
    .num_core_p  (num_core_lp)
  ) UUT (
    .clk_i                  (clk),
    .rst_n_i                (rst_n),
    .fwd_header_i           (fwd_header),
    .fwd_header_v_i         (fwd_header_v),
    .fwd_has_data_i         (fwd_has_data),
    .fwd_header_ready_and_o (fwd_header_ready_and),
    .fwd_data_i             (fwd_data),
    .fwd_data_v_i           (fwd_data_v),
    .fwd_last_i             (fwd_last),
    .fwd_data_ready_and_o   (fwd_data_ready_and),
    .rev_header_o           (rev_header),
    .rev_header_v_o         (rev_header_v),
    .rev_has_data_o         (rev_has_data),
    .rev_header_ready_and_i (rev_header_ready_and),
    .rev_data_o             (rev_data),
    .rev_data_v_o           (rev_data_v),
    .rev_last_o             (rev_last),
    .rev_data_ready_and_i   (rev_data_ready_and),
    .finish_o               (finish),
    .trace_en_o             (trace_en)
  );

  host_bridge_checker #(
    .beat_width_p(beat_width_lp),
    .num_core_p  (num_core_lp)
  ) u_checker (
    .clk_i                  (clk),
    .rst_n_i                (rst_n),
    .exp_push_i             (exp_push),
    .exp_test_i             (exp_test),
    .exp_header_i           (exp_header),
    .exp_data_i             (exp_data),
    .exp_beats_i            (exp_beats),
    .exp_finish_i           (exp_finish),
    .exp_trace_i            (exp_trace),
    .fwd_header_ready_and_i (fwd_header_ready_and),
    .rev_header_i           (rev_header),
    .rev_header_v_i         (rev_header_v),
    .rev_has_data_i         (rev_has_data),
    .rev_header_ready_and_i (rev_header_ready_and),
    .rev_data_i             (rev_data),
    .rev_data_v_i           (rev_data_v),
    .rev_last_i             (rev_last),
    .rev_data_ready_and_i   (rev_data_ready_and),
    .finish_i               (finish),
    .trace_en_i             (trace_en),
    .error_count_o          (error_count),
    .resp_count_o           (resp_count)
  );

  always #4 clk = ~clk;

  // Random back-pressure on the reverse port
  always @(negedge clk)
  begin
    rev_header_ready_and = ($urandom % 4) != 0;
    rev_data_ready_and   = ($urandom % 4) != 0;
  end

  // At least one beat, otherwise size in bits over the beat width
  function automatic int size_beats(input mem_size_e sz);
    int size_bits;
    size_bits = 8 * (1 << int'(sz));
    if (size_bits > beat_width_lp)
      return size_bits / beat_width_lp;
    return 1;
  endfunction

  function automatic logic [63:0] keep_beats(input logic [63:0] value, input int beats);
    if (beats * beat_width_lp >= 64)
      return value;
    return value & ((64'd1 << (beats * beat_width_lp)) - 64'd1);
  endfunction

  // Expected response data, response beats and next register state
  function automatic void ref_model(
    input  mem_header_s hdr,
    input  logic [63:0] wdata,
    input  regs_model_s cur,
    output logic [63:0] rdata,
    output int          beats,
    output regs_model_s nxt
  );
    logic [63:0] value;
    int          core;
    nxt   = cur;
    value = '0;
    if (hdr.addr == host_trace_addr_gp)
    begin
      value = 64'(cur.trace);
      if (hdr.op == e_mem_wr)
        nxt.trace = trace_en_s'(wdata[$bits(trace_en_s)-1:0]);
    end
    for (core = 0; core < num_core_lp; core++)
    begin
      if (hdr.addr == host_finish_base_gp + 20'(8 * core))
      begin
        value = 64'(cur.finish[core]);
        if (hdr.op == e_mem_wr)
          nxt.finish[core] = wdata[0];
      end
    end
    beats = (hdr.op == e_mem_wr) ? 0 : size_beats(hdr.size);
    rdata = (hdr.op == e_mem_wr) ? 64'd0 : keep_beats(value, beats);
  endfunction

  task automatic send_request(input logic [3:0] test, input mem_op_e req_op,
                              input logic [19:0] req_addr, input mem_size_e req_size,
                              input logic [63:0] data);
    mem_header_s hdr;
    logic [63:0] wdata;
    logic [63:0] rdata;
    int          n_beats;
    int          resp_beats;
    int          i;
    logic        taken;
    regs_model_s nxt;
    hdr.op      = req_op;
    hdr.addr    = req_addr;
    hdr.size    = req_size;
    hdr.payload = 4'($urandom);
    n_beats     = size_beats(req_size);
    wdata       = (req_op == e_mem_wr) ? keep_beats(data, n_beats) : 64'd0;
    ref_model(hdr, wdata, model, rdata, resp_beats, nxt);
    model        = nxt;
    exp_push     = 1'b1;
    exp_test     = test;
    exp_header   = hdr;
    exp_data     = rdata;
    exp_beats    = 4'(resp_beats);
    exp_finish   = nxt.finish;
    exp_trace    = nxt.trace;
    fwd_header   = hdr;
    fwd_header_v = 1'b1;
    fwd_has_data = (req_op == e_mem_wr);
    taken        = 1'b0;
    // Ready depends only on DUT state, so the mid-cycle value holds through the edge
    while (!taken)
    begin
      taken = fwd_header_ready_and;
      @(negedge clk);
      exp_push = 1'b0;
    end
    fwd_header_v = 1'b0;
    sent++;
    if (req_op == e_mem_wr)
    begin
      for (i = 0; i < n_beats; i++)
      begin
        fwd_data   = wdata[i*beat_width_lp +: beat_width_lp];
        fwd_data_v = 1'b1;
        fwd_last   = (i == n_beats - 1);
        taken      = 1'b0;
        while (!taken)
        begin
          taken = fwd_data_ready_and;
          @(negedge clk);
        end
      end
      fwd_data_v = 1'b0;
      fwd_last   = 1'b0;
    end
  endtask

  task automatic wait_drained();
    while (resp_count != sent)
      @(negedge clk);
  endtask

  initial
  begin
    repeat (timeout_cycles_lp) @(posedge clk);
    $display("Timeout: responses still missing after %0d cycles", timeout_cycles_lp);
    $display("Test failed");
    $finish;
  end

  initial
  begin
    void'($urandom(97460));
    clk                  = 1'b0;
    rst_n                = 1'b0;
    fwd_header           = '0;
    fwd_header_v         = 1'b0;
    fwd_has_data         = 1'b0;
    fwd_data             = '0;
    fwd_data_v           = 1'b0;
    fwd_last             = 1'b0;
    rev_header_ready_and = 1'b0;
    rev_data_ready_and   = 1'b0;
    exp_push             = 1'b0;
    exp_test             = '0;
    exp_header           = '0;
    exp_data             = '0;
    exp_beats            = '0;
    exp_finish           = '0;
    exp_trace            = '0;
    model                = '0;
    sent                 = 0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    for (k = 0; k < num_trace_lp; k++)
    begin
      send_request(t_trace_lp, e_mem_wr, host_trace_addr_gp, e_size_8, 64'(13'($urandom)));
      send_request(t_trace_lp, e_mem_rd, host_trace_addr_gp, e_size_8, 64'd0);
      wait_drained();
    end

    for (k = 0; k < num_core_lp; k++)
    begin
      addr = host_finish_base_gp + 20'(8 * k);
      send_request(t_finish_lp, e_mem_wr, addr, e_size_8, 64'd1);
      wait_drained();
      send_request(t_finish_lp, e_mem_rd, addr, e_size_8, 64'd0);
      send_request(t_finish_lp, e_mem_wr, addr, e_size_8, 64'd0);
      send_request(t_finish_lp, e_mem_rd, addr, e_size_8, 64'd0);
      wait_drained();
    end

    // Nonzero state first so a stray write would show
    send_request(t_unmapped_lp, e_mem_wr, host_finish_base_gp, e_size_8, 64'd1);
    for (k = 0; k < num_unmapped_lp; k++)
    begin
      case (k % 4)
        0:       addr = host_trace_addr_gp + 20'd8;
        1:       addr = host_finish_base_gp + 20'(8 * num_core_lp);
        2:       addr = host_finish_base_gp + 20'd4;
        default: addr = 20'd0;
      endcase
      send_request(t_unmapped_lp, e_mem_wr, addr, e_size_8, {$urandom, $urandom} | 64'd1);
      send_request(t_unmapped_lp, e_mem_rd, addr, e_size_8, 64'd0);
      wait_drained();
    end

    for (k = 0; k < 4; k++)
    begin
      size = mem_size_e'(k);
      send_request(t_sizes_lp, e_mem_wr, host_trace_addr_gp, size, {$urandom, $urandom});
      send_request(t_sizes_lp, e_mem_rd, host_trace_addr_gp, size, 64'd0);
    end
    wait_drained();

    for (k = 0; k < num_random_lp; k++)
    begin
      op   = mem_op_e'($urandom % 2);
      size = mem_size_e'($urandom % 4);
      case ($urandom % 4)
        0:       addr = host_trace_addr_gp;
        1:       addr = host_finish_base_gp + 20'(8 * ($urandom % num_core_lp));
        2:       addr = 20'($urandom);
        default: addr = host_finish_base_gp + 20'(4 * ($urandom % 16));
      endcase
      send_request(t_random_lp, op, addr, size, {$urandom, $urandom});
      repeat ($urandom % 4) @(negedge clk);
    end
    wait_drained();

    repeat (4) @(negedge clk);
    $display("Responses: %0d of %0d, errors: %0d", resp_count, sent, error_count);
    if (error_count == 0 && resp_count == sent)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/host_bridge_checker.sv
// Host bridge response checker
`timescale 1ns/1ps
`default_nettype none

module host_bridge_checker #(
  parameter int unsigned beat_width_p = 32,
  parameter int unsigned num_core_p   = 4
) (
  input  wire                           clk_i,
  input  wire                           rst_n_i,
  input  wire                           exp_push_i,
  input  wire [3:0]                     exp_test_i,
  input  wire mem_msg_pkg::mem_header_s exp_header_i,
  input  wire [63:0]                    exp_data_i,
  input  wire [3:0]                     exp_beats_i,
  input  wire [num_core_p-1:0]          exp_finish_i,
  input  wire host_map_pkg::trace_en_s  exp_trace_i,
  input  wire                           fwd_header_ready_and_i,
  input  wire mem_msg_pkg::mem_header_s rev_header_i,
  input  wire                           rev_header_v_i,
  input  wire                           rev_has_data_i,
  input  wire                           rev_header_ready_and_i,
  input  wire [beat_width_p-1:0]        rev_data_i,
  input  wire                           rev_data_v_i,
  input  wire                           rev_last_i,
  input  wire                           rev_data_ready_and_i,
  input  wire [num_core_p-1:0]          finish_i,
  input  wire host_map_pkg::trace_en_s  trace_en_i,
  output int                            error_count_o,
  output int                            resp_count_o
);

  import mem_msg_pkg::*;
  import host_map_pkg::*;

  localparam int max_beats_lp = dword_width_gp / beat_width_p;

  typedef struct packed {
    logic [3:0]                test;
    mem_header_s               header;
    logic [dword_width_gp-1:0] data;
    logic [3:0]                beats;
    logic [num_core_p-1:0]     finish;
    trace_en_s                 trace;
  } exp_s;

  exp_s                      exp_q[$];
  exp_s                      cur;
  logic [dword_width_gp-1:0] acc;
  int                        beat_cnt;
  logic                      in_data;
  logic                      reset_checked;

  initial
  begin
    error_count_o = 0;
    resp_count_o  = 0;
    in_data       = 1'b0;
    reset_checked = 1'b0;
  end

  function automatic string test_name(input logic [3:0] id);
    case (id)
      4'd1:    return "trace_rw";
      4'd2:    return "finish_rw";
      4'd3:    return "unmapped";
      4'd4:    return "size_sweep";
      4'd5:    return "random_traffic";
      default: return "reset";
    endcase
  endfunction

  task automatic report_mismatch(input string what, input logic [63:0] expected,
                                 input logic [63:0] actual);
    error_count_o++;
    $display("[ERROR] %s %s: expected 0x%0h, actual 0x%0h",
             test_name(cur.test), what, expected, actual);
  endtask

  task automatic report_fault(input string what);
    error_count_o++;
    $display("Protocol fault at %0t ns: %s", $time, what);
  endtask

  // Register outputs only match the model once nothing is in flight
  task automatic retire_response();
    void'(exp_q.pop_front());
    resp_count_o++;
    in_data = 1'b0;
    if (exp_q.size() == 0)
    begin
      if (finish_i !== cur.finish)
        report_mismatch("finish_o", 64'(cur.finish), 64'(finish_i));
      if (trace_en_i !== cur.trace)
        report_mismatch("trace_en_o", 64'(cur.trace), 64'(trace_en_i));
    end
  endtask

  always @(posedge clk_i)
  begin
    if (exp_push_i)
      exp_q.push_back({exp_test_i, exp_header_i, exp_data_i, exp_beats_i,
                       exp_finish_i, exp_trace_i});

    if (!rst_n_i)
      in_data = 1'b0;
    else
    begin
      if (!reset_checked)
      begin
        reset_checked = 1'b1;
        cur           = '0;
        if (rev_header_v_i || rev_data_v_i || !fwd_header_ready_and_i)
          report_fault("handshake outputs not idle after reset");
        if (finish_i !== '0)
          report_mismatch("finish_o", 64'd0, 64'(finish_i));
        if (trace_en_i !== '0)
          report_mismatch("trace_en_o", 64'd0, 64'(trace_en_i));
      end

      if (rev_header_v_i && rev_header_ready_and_i)
      begin
        if (exp_q.size() == 0)
          report_fault("response header arrived with no request outstanding");
        else
        begin
          cur = exp_q[0];
          if (rev_header_i !== cur.header)
            report_mismatch("header", 64'(cur.header), 64'(rev_header_i));
          if (rev_has_data_i !== (cur.beats != 0))
            report_mismatch("has_data", 64'(cur.beats != 0), 64'(rev_has_data_i));
          if (cur.beats == 0)
            retire_response();
          else
          begin
            in_data  = 1'b1;
            beat_cnt = 0;
            acc      = '0;
          end
        end
      end

      if (rev_data_v_i && rev_data_ready_and_i)
      begin
        if (!in_data)
          report_fault("data beat arrived without a response header");
        else
        begin
          if (beat_cnt < max_beats_lp)
            acc[beat_cnt*beat_width_p +: beat_width_p] = rev_data_i;
          beat_cnt++;
          if (rev_last_i !== (beat_cnt == int'(cur.beats)))
            report_mismatch("last flag", 64'(beat_cnt == int'(cur.beats)), 64'(rev_last_i));
          if (rev_last_i)
          begin
            if (acc !== cur.data)
              report_mismatch("read data", cur.data, acc);
            retire_response();
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/host_bridge_top.sv
// Host bridge top level
`timescale 1ns/1ps
`default_nettype none

module host_bridge_top #(
  parameter int unsigned beat_width_p = 32,
  parameter int unsigned num_core_p   = 4
) (
  input  wire                             clk_i,
  input  wire                             rst_n_i,

  input  wire mem_msg_pkg::mem_header_s   fwd_header_i,
  input  wire                             fwd_header_v_i,
  input  wire                             fwd_has_data_i,
  output logic                            fwd_header_ready_and_o,
  input  wire [beat_width_p-1:0]          fwd_data_i,
  input  wire                             fwd_data_v_i,
  input  wire                             fwd_last_i,
  output logic                            fwd_data_ready_and_o,

  output mem_msg_pkg::mem_header_s        rev_header_o,
  output logic                            rev_header_v_o,
  output logic                            rev_has_data_o,
  input  wire                             rev_header_ready_and_i,
  output logic [beat_width_p-1:0]         rev_data_o,
  output logic                            rev_data_v_o,
  output logic                            rev_last_o,
  input  wire                             rev_data_ready_and_i,

  output logic [num_core_p-1:0]           finish_o,
  output host_map_pkg::trace_en_s         trace_en_o
);

  import mem_msg_pkg::*;

  // Lite links around the register block
  lite_msg_s req_lite;
  logic      req_lite_v;
  logic      req_lite_ready_and;
  lite_msg_s resp_lite;
  logic      resp_lite_v;
  logic      resp_lite_ready_and;

  burst_to_lite #(
    .beat_width_p(beat_width_p)
  ) u_burst_to_lite (
    .clk_i                  (clk_i),
    .rst_n_i                (rst_n_i),
    .fwd_header_i           (fwd_header_i),
    .fwd_header_v_i         (fwd_header_v_i),
    .fwd_has_data_i         (fwd_has_data_i),
    .fwd_header_ready_and_o (fwd_header_ready_and_o),
    .fwd_data_i             (fwd_data_i),
    .fwd_data_v_i           (fwd_data_v_i),
    .fwd_last_i             (fwd_last_i),
    .fwd_data_ready_and_o   (fwd_data_ready_and_o),
    .lite_o                 (req_lite),
    .lite_v_o               (req_lite_v),
    .lite_ready_and_i       (req_lite_ready_and)
  );

  host_regs #(
    .num_core_p(num_core_p)
  ) u_host_regs (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .req_i            (req_lite),
    .req_v_i          (req_lite_v),
    .req_ready_and_o  (req_lite_ready_and),
    .resp_o           (resp_lite),
    .resp_v_o         (resp_lite_v),
    .resp_ready_and_i (resp_lite_ready_and),
    .finish_o         (finish_o),
    .trace_en_o       (trace_en_o)
  );

  lite_to_burst #(
    .beat_width_p(beat_width_p)
  ) u_lite_to_burst (
    .clk_i                  (clk_i),
    .rst_n_i                (rst_n_i),
    .lite_i                 (resp_lite),
    .lite_v_i               (resp_lite_v),
    .lite_ready_and_o       (resp_lite_ready_and),
    .rev_header_o           (rev_header_o),
    .rev_header_v_o         (rev_header_v_o),
    .rev_has_data_o         (rev_has_data_o),
    .rev_header_ready_and_i (rev_header_ready_and_i),
    .rev_data_o             (rev_data_o),
    .rev_data_v_o           (rev_data_v_o),
    .rev_last_o             (rev_last_o),
    .rev_data_ready_and_i   (rev_data_ready_and_i)
  );

endmodule

`default_nettype wire

//--- rtl/host_regs.sv
// Host finish and trace registers
`timescale 1ns/1ps
`default_nettype none

module host_regs #(
  parameter int unsigned num_core_p = 4
) (
  input  wire                             clk_i,
  input  wire                             rst_n_i,
  input  wire mem_msg_pkg::lite_msg_s     req_i,
  input  wire                             req_v_i,
  output logic                            req_ready_and_o,
  output mem_msg_pkg::lite_msg_s          resp_o,
  output logic                            resp_v_o,
  input  wire                             resp_ready_and_i,
  output logic [num_core_p-1:0]           finish_o,
  output host_map_pkg::trace_en_s         trace_en_o
);

  import mem_msg_pkg::*;
  import host_map_pkg::*;

  localparam int trace_width_lp = $bits(trace_en_s);

  lite_msg_s                 resp_r;
  logic                      resp_v_r;
  logic [num_core_p-1:0]     finish_r;
  trace_en_s                 trace_r;
  logic                      req_fire;
  logic                      is_write;
  logic                      trace_hit;
  logic [num_core_p-1:0]     finish_hit;
  logic [dword_width_gp-1:0] rd_data;

  assign req_ready_and_o = ~resp_v_r;
  assign req_fire  = req_v_i & req_ready_and_o;
  assign is_write  = (req_i.header.op == e_mem_wr);
  assign trace_hit = (req_i.header.addr == host_trace_addr_gp);

  // Address decode and read mux, unmapped reads give zero
  always_comb
  begin
    finish_hit = '0;
    rd_data    = '0;
    for (int i = 0; i < num_core_p; i++)
    begin
      finish_hit[i] = (req_i.header.addr ==
                       addr_width_gp'(host_finish_base_gp + host_finish_stride_gp * i));
      if (finish_hit[i])
        rd_data = dword_width_gp'(finish_r[i]);
    end
    if (trace_hit)
      rd_data = dword_width_gp'(trace_r);
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      resp_v_r <= 1'b0;
      finish_r <= '0;
      trace_r  <= '0;
    end
    else
    begin
      if (req_fire)
        resp_v_r <= 1'b1;
      else if (resp_v_r && resp_ready_and_i)
        resp_v_r <= 1'b0;

      if (req_fire && is_write)
      begin
        if (trace_hit)
          trace_r <= trace_en_s'(req_i.data[trace_width_lp-1:0]);
        for (int i = 0; i < num_core_p; i++)
        begin
          if (finish_hit[i])
            finish_r[i] <= req_i.data[0];
        end
      end
    end
  end

  // Header echoes the request
  always_ff @(posedge clk_i)
  begin
    if (req_fire)
    begin
      resp_r.header <= req_i.header;
      resp_r.data   <= is_write ? '0 : rd_data;
    end
  end

  assign resp_o     = resp_r;
  assign resp_v_o   = resp_v_r;
  assign finish_o   = finish_r;
  assign trace_en_o = trace_r;

  // Pending response holds until taken
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (resp_v_r && !resp_ready_and_i) |=> (resp_v_r && $stable(resp_r)))
    else $error("host_regs: response changed while stalled");

endmodule

`default_nettype wire

//--- rtl/lite_to_burst.sv
// Reverse burst splitter
`timescale 1ns/1ps
`default_nettype none

module lite_to_burst #(
  parameter int unsigned beat_width_p = 32
) (
  input  wire                             clk_i,
  input  wire                             rst_n_i,
  input  wire mem_msg_pkg::lite_msg_s     lite_i,
  input  wire                             lite_v_i,
  output logic                            lite_ready_and_o,
  output mem_msg_pkg::mem_header_s        rev_header_o,
  output logic                            rev_header_v_o,
  output logic                            rev_has_data_o,
  input  wire                             rev_header_ready_and_i,
  output logic [beat_width_p-1:0]         rev_data_o,
  output logic                            rev_data_v_o,
  output logic                            rev_last_o,
  input  wire                             rev_data_ready_and_i
);

  import mem_msg_pkg::*;

  localparam int unsigned max_beats_lp = dword_width_gp / beat_width_p;
  localparam int unsigned cnt_width_lp = (max_beats_lp > 1) ? $clog2(max_beats_lp) : 1;

  typedef enum logic [1:0] {
    e_idle,
    e_header,
    e_data
  } state_e;

  state_e                  state_r;
  lite_msg_s               msg_r;
  logic [cnt_width_lp-1:0] cnt_r;
  logic [cnt_width_lp-1:0] last_cnt;
  logic                    lite_fire;
  logic                    hdr_fire;
  logic                    data_fire;

  assign lite_ready_and_o = (state_r == e_idle);
  assign lite_fire = lite_v_i & lite_ready_and_o;
  assign hdr_fire  = rev_header_v_o & rev_header_ready_and_i;
  assign data_fire = rev_data_v_o & rev_data_ready_and_i;

  assign last_cnt = cnt_width_lp'(beats_for_size(msg_r.header.size, beat_width_p) - 1);

  // Only read responses carry data
  assign rev_header_o   = msg_r.header;
  assign rev_header_v_o = (state_r == e_header);
  assign rev_has_data_o = (msg_r.header.op == e_mem_rd);

  assign rev_data_o   = msg_r.data[cnt_r*beat_width_p +: beat_width_p];
  assign rev_data_v_o = (state_r == e_data);
  assign rev_last_o   = rev_data_v_o & (cnt_r == last_cnt);

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_r <= e_idle;
      cnt_r   <= '0;
    end
    else
    begin
      case (state_r)
        e_idle:
        begin
          if (lite_fire)
            state_r <= e_header;
        end
        e_header:
        begin
          if (hdr_fire)
          begin
            cnt_r   <= '0;
            state_r <= rev_has_data_o ? e_data : e_idle;
          end
        end
        e_data:
        begin
          if (data_fire)
          begin
            cnt_r <= cnt_r + 1'b1;
            if (rev_last_o)
              state_r <= e_idle;
          end
        end
        default:
          state_r <= e_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (lite_fire)
      msg_r <= lite_i;
  end

  // Stalled beat holds its data and last flag
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (rev_data_v_o && !rev_data_ready_and_i) |=>
      (rev_data_v_o && $stable(rev_data_o) && $stable(rev_last_o)))
    else $error("lite_to_burst: data beat changed while stalled");

endmodule

`default_nettype wire

//--- rtl/burst_to_lite.sv
// Forward burst gatherer
`timescale 1ns/1ps
`default_nettype none

module burst_to_lite #(
  parameter int unsigned beat_width_p = 32
) (
  input  wire                             clk_i,
  input  wire                             rst_n_i,
  input  wire mem_msg_pkg::mem_header_s   fwd_header_i,
  input  wire                             fwd_header_v_i,
  input  wire                             fwd_has_data_i,
  output logic                            fwd_header_ready_and_o,
  input  wire [beat_width_p-1:0]          fwd_data_i,
  input  wire                             fwd_data_v_i,
  input  wire                             fwd_last_i,
  output logic                            fwd_data_ready_and_o,
  output mem_msg_pkg::lite_msg_s          lite_o,
  output logic                            lite_v_o,
  input  wire                             lite_ready_and_i
);

  import mem_msg_pkg::*;

  localparam int unsigned max_beats_lp = dword_width_gp / beat_width_p;
  localparam int unsigned cnt_width_lp = (max_beats_lp > 1) ? $clog2(max_beats_lp) : 1;

  typedef enum logic [1:0] {
    e_idle,
    e_data,
    e_full
  } state_e;

  state_e                    state_r;
  mem_header_s               hdr_r;
  logic [dword_width_gp-1:0] data_r;
  logic [cnt_width_lp-1:0]   cnt_r;
  logic [cnt_width_lp-1:0]   last_cnt;
  logic                      last_beat;
  logic                      hdr_fire;
  logic                      data_fire;

  assign fwd_header_ready_and_o = (state_r == e_idle);
  assign fwd_data_ready_and_o   = (state_r == e_data);
  assign hdr_fire  = fwd_header_v_i & fwd_header_ready_and_o;
  assign data_fire = fwd_data_v_i & fwd_data_ready_and_o;

  assign last_cnt  = cnt_width_lp'(beats_for_size(hdr_r.size, beat_width_p) - 1);
  assign last_beat = (cnt_r == last_cnt);

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_r <= e_idle;
      cnt_r   <= '0;
    end
    else
    begin
      case (state_r)
        e_idle:
        begin
          if (hdr_fire)
          begin
            cnt_r   <= '0;
            state_r <= fwd_has_data_i ? e_data : e_full;
          end
        end
        e_data:
        begin
          if (data_fire)
          begin
            cnt_r <= cnt_r + 1'b1;
            if (last_beat)
              state_r <= e_full;
          end
        end
        e_full:
        begin
          if (lite_ready_and_i)
            state_r <= e_idle;
        end
        default:
          state_r <= e_idle;
      endcase
    end
  end

  // Beats land least significant first
  always_ff @(posedge clk_i)
  begin
    if (hdr_fire)
    begin
      hdr_r  <= fwd_header_i;
      data_r <= '0;
    end
    if (data_fire)
      data_r[cnt_r*beat_width_p +: beat_width_p] <= fwd_data_i;
  end

  assign lite_o.header = hdr_r;
  assign lite_o.data   = data_r;
  assign lite_v_o      = (state_r == e_full);

  // Sender's last flag agrees with the size in the header
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    data_fire |-> (fwd_last_i == last_beat))
    else $error("burst_to_lite: last flag does not match beat count");

  // No stray beat after a header without data
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (hdr_fire && !fwd_has_data_i) |=> !fwd_data_v_i)
    else $error("burst_to_lite: data beat for a header without data");

endmodule

`default_nettype wire

//--- rtl/host_map_pkg.sv
// Host device address map
`default_nettype none

package host_map_pkg;

  localparam logic [mem_msg_pkg::addr_width_gp-1:0] host_trace_addr_gp  = 'h0_1000;
  localparam logic [mem_msg_pkg::addr_width_gp-1:0] host_finish_base_gp = 'h0_2000;

  // One finish register per core, a dword apart
  localparam int host_finish_stride_gp = 8;

  // Bit 0 is icache
  typedef struct packed {
    logic dev;
    logic cosim;
    logic branch_profile;
    logic pc_profile;
    logic pc_gen;
    logic core_profile;
    logic cmt;
    logic vm;
    logic dram;
    logic cce;
    logic lce;
    logic dcache;
    logic icache;
  } trace_en_s;

endpackage

`default_nettype wire

//--- rtl/mem_msg_pkg.sv
// Memory message definitions
`default_nettype none

package mem_msg_pkg;

  localparam int addr_width_gp    = 20;
  localparam int dword_width_gp   = 64;
  localparam int payload_width_gp = 4;

  typedef enum logic [0:0] {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } mem_op_e;

  // Log2 of the byte count
  typedef enum logic [1:0] {
    e_size_1 = 2'd0,
    e_size_2 = 2'd1,
    e_size_4 = 2'd2,
    e_size_8 = 2'd3
  } mem_size_e;

  typedef struct packed {
    mem_op_e                     op;
    logic [addr_width_gp-1:0]    addr;
    mem_size_e                   size;
    logic [payload_width_gp-1:0] payload;
  } mem_header_s;

  typedef struct packed {
    mem_header_s               header;
    logic [dword_width_gp-1:0] data;
  } lite_msg_s;

  // Beats per burst, at least one even for narrow transfers
  function automatic int unsigned beats_for_size(mem_size_e size, int unsigned beat_width);
    int unsigned size_bits;
    size_bits = 8 << size;
    return (size_bits > beat_width) ? size_bits / beat_width : 1;
  endfunction

endpackage

`default_nettype wire
